// File: source/vproc_pkg.sv
// shared constants and types for the vector issue subsystem
// register fields in the instruction word are fixed at 5 bits (32 vregs)
`default_nettype none

package vproc_pkg;

    localparam int unsigned VREG_W   = 32;
    localparam int unsigned LANE_W   = 8;
    localparam int unsigned LANE_CNT = 4;
    localparam int unsigned INSTR_W  = 32;
    localparam int unsigned PIPE_CNT = 3;  // alu, mul, out

    typedef enum logic [3:0] {
        OP_ADD = 4'd0,
        OP_SUB = 4'd1,
        OP_XOR = 4'd2,
        OP_LI  = 4'd3,
        OP_MUL = 4'd4,
        OP_OUT = 4'd5
    } opcode_e;

    // values double as index into the per-unit issue vectors
    typedef enum logic [1:0] {
        UNIT_ALU  = 2'd0,
        UNIT_MUL  = 2'd1,
        UNIT_OUT  = 2'd2,
        UNIT_NONE = 2'd3
    } unit_e;

    typedef struct packed {
        opcode_e     opcode;
        logic [4:0]  vd;
        logic [4:0]  vs1;
        logic [4:0]  vs2;
        logic [12:0] unused;
    } vinstr_reg_t;

    typedef struct packed {
        opcode_e           opcode;
        logic [4:0]        vd;
        logic [LANE_W-1:0] imm;
        logic [14:0]       unused;
    } vinstr_imm_t;

    // same word, register or immediate view
    typedef union packed {
        vinstr_reg_t r;
        vinstr_imm_t i;
    } vinstr_u;

endpackage

`default_nettype wire

// File: source/vproc_issue_if.sv
// one issued operation from the dispatcher to a unit, valid/ready handshake
`timescale 1ns/1ps
`default_nettype none

interface vproc_issue_if #(
    parameter int unsigned MAX_VADDR_W = 5
);
    logic                         valid;
    logic                         ready;
    vproc_pkg::opcode_e           op;
    logic [MAX_VADDR_W-1:0]       vd;
    logic [vproc_pkg::VREG_W-1:0] opa;
    logic [vproc_pkg::VREG_W-1:0] opb;  // vs2 operand or broadcast imm

    modport dispatcher (output valid, op, vd, opa, opb, input ready);
    modport unit (input valid, op, vd, opa, opb, output ready);

endinterface

`default_nettype wire

// File: source/vproc_decoder.sv
// one-entry decode stage; unknown opcodes leave with UNIT_NONE and empty maps
// MAX_VADDR_W has to match the 5-bit register fields of the instruction word
`timescale 1ns/1ps
`default_nettype none

module vproc_decoder #(
    parameter int unsigned MAX_VADDR_W = 5
) (
    input  logic                              clk_i,
    input  logic                              async_rst_ni,
    input  logic                              instr_valid_i,
    output logic                              instr_ready_o,
    input  vproc_pkg::vinstr_u                instr_i,
    output logic                              dec_valid_o,
    input  logic                              dec_ready_i,
    output vproc_pkg::opcode_e                dec_op_o,
    output vproc_pkg::unit_e                  dec_unit_o,
    output logic [MAX_VADDR_W-1:0]            dec_vd_o,
    output logic [MAX_VADDR_W-1:0]            dec_vs1_o,
    output logic [MAX_VADDR_W-1:0]            dec_vs2_o,
    output logic [vproc_pkg::LANE_W-1:0]      dec_imm_o,
    output logic [(1 << MAX_VADDR_W)-1:0]     dec_wr_map_o,
    output logic [(1 << MAX_VADDR_W)-1:0]     dec_rd_map_o
);
    localparam int unsigned VADDR_CNT = 1 << MAX_VADDR_W;

    logic                         valid_q;
    vproc_pkg::unit_e             unit_d;
    logic [vproc_pkg::LANE_W-1:0] imm_d;
    logic [VADDR_CNT-1:0]         wr_map_d;
    logic [VADDR_CNT-1:0]         rd_map_d;

    assign instr_ready_o = ~valid_q | dec_ready_i;  // refill as the entry leaves
    assign dec_valid_o   = valid_q;

    always_comb begin
        unit_d   = vproc_pkg::UNIT_NONE;
        imm_d    = '0;
        wr_map_d = '0;
        rd_map_d = '0;
        case (instr_i.r.opcode)
            vproc_pkg::OP_ADD, vproc_pkg::OP_SUB, vproc_pkg::OP_XOR, vproc_pkg::OP_MUL: begin
                unit_d   = (instr_i.r.opcode == vproc_pkg::OP_MUL) ? vproc_pkg::UNIT_MUL
                                                                     : vproc_pkg::UNIT_ALU;
                wr_map_d = VADDR_CNT'(1) << instr_i.r.vd;
                rd_map_d = (VADDR_CNT'(1) << instr_i.r.vs1) | (VADDR_CNT'(1) << instr_i.r.vs2);
            end
            vproc_pkg::OP_LI: begin
                unit_d   = vproc_pkg::UNIT_ALU;
                imm_d    = instr_i.i.imm;
                wr_map_d = VADDR_CNT'(1) << instr_i.i.vd;  // reads nothing
            end
            vproc_pkg::OP_OUT: begin
                unit_d   = vproc_pkg::UNIT_OUT;
                rd_map_d = VADDR_CNT'(1) << instr_i.r.vs1;
            end
            default: begin
                unit_d = vproc_pkg::UNIT_NONE;  // dropped by the dispatcher
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge async_rst_ni) begin
        if (!async_rst_ni) begin
            valid_q <= 1'b0;
        end else if (instr_ready_o) begin
            valid_q <= instr_valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (instr_valid_i && instr_ready_o) begin
            dec_op_o     <= instr_i.r.opcode;
            dec_unit_o   <= unit_d;
            dec_vd_o     <= instr_i.r.vd;  // same bits in both views
            dec_vs1_o    <= instr_i.r.vs1;
            dec_vs2_o    <= instr_i.r.vs2;
            dec_imm_o    <= imm_d;
            dec_wr_map_o <= wr_map_d;
            dec_rd_map_o <= rd_map_d;
        end
    end

endmodule

`default_nettype wire

// File: source/vproc_dispatcher.sv
// blocks the head entry on any pending write to its destination or sources
// operands come straight from the register file read ports
`timescale 1ns/1ps
`default_nettype none

module vproc_dispatcher #(
    parameter int unsigned MAX_VADDR_W = 5
) (
    input  logic                              clk_i,
    input  logic                              async_rst_ni,
    input  logic                              dec_valid_i,
    output logic                              dec_ready_o,
    input  vproc_pkg::opcode_e                dec_op_i,
    input  vproc_pkg::unit_e                  dec_unit_i,
    input  logic [MAX_VADDR_W-1:0]            dec_vd_i,
    input  logic [vproc_pkg::LANE_W-1:0]      dec_imm_i,
    input  logic [(1 << MAX_VADDR_W)-1:0]     dec_wr_map_i,
    input  logic [(1 << MAX_VADDR_W)-1:0]     dec_rd_map_i,
    input  logic [vproc_pkg::VREG_W-1:0]      rf_opa_i,
    input  logic [vproc_pkg::VREG_W-1:0]      rf_opb_i,
    vproc_issue_if.dispatcher                 alu_if,
    vproc_issue_if.dispatcher                 mul_if,
    vproc_issue_if.dispatcher                 out_if,
    input  logic [(1 << MAX_VADDR_W)-1:0]     wb_clear_i,
    output logic [(1 << MAX_VADDR_W)-1:0]     pend_map_o
);
    localparam int unsigned VADDR_CNT = 1 << MAX_VADDR_W;

    logic [VADDR_CNT-1:0]           pend_q;  // registers with a write in flight
    logic                           hazard;
    logic                           fire;
    logic [vproc_pkg::PIPE_CNT-1:0] issue_valid;
    logic [vproc_pkg::PIPE_CNT-1:0] issue_ready;
    logic [vproc_pkg::VREG_W-1:0]   opb;

    assign hazard = |((dec_wr_map_i | dec_rd_map_i) & pend_q);

    // steer to the one matching unit
    always_comb begin
        issue_valid = '0;
        if (dec_valid_i && !hazard && dec_unit_i != vproc_pkg::UNIT_NONE) begin
            issue_valid[dec_unit_i] = 1'b1;
        end
    end

    assign issue_ready = {out_if.ready, mul_if.ready, alu_if.ready};  // unit_e order
    assign fire        = |(issue_valid & issue_ready);
    assign dec_ready_o = fire | (dec_valid_i & (dec_unit_i == vproc_pkg::UNIT_NONE));

    assign opb = (dec_op_i == vproc_pkg::OP_LI) ? {vproc_pkg::LANE_CNT{dec_imm_i}} : rf_opb_i;

    assign alu_if.valid = issue_valid[vproc_pkg::UNIT_ALU];
    assign alu_if.op    = dec_op_i;
    assign alu_if.vd    = dec_vd_i;
    assign alu_if.opa   = rf_opa_i;
    assign alu_if.opb   = opb;

    assign mul_if.valid = issue_valid[vproc_pkg::UNIT_MUL];
    assign mul_if.op    = dec_op_i;
    assign mul_if.vd    = dec_vd_i;
    assign mul_if.opa   = rf_opa_i;
    assign mul_if.opb   = opb;

    assign out_if.valid = issue_valid[vproc_pkg::UNIT_OUT];
    assign out_if.op    = dec_op_i;
    assign out_if.vd    = dec_vd_i;
    assign out_if.opa   = rf_opa_i;
    assign out_if.opb   = opb;

    always_ff @(posedge clk_i or negedge async_rst_ni) begin
        if (!async_rst_ni) begin
            pend_q <= '0;
        end else begin
            pend_q <= (pend_q & ~wb_clear_i) | (fire ? dec_wr_map_i : '0);
        end
    end

    assign pend_map_o = pend_q;

endmodule

`default_nettype wire

// File: source/vproc_vregfile.sv
// 32 vregs with two combinational read ports and one write port
// MUL wins over ALU when both write in the same cycle
`timescale 1ns/1ps
`default_nettype none

module vproc_vregfile #(
    parameter int unsigned MAX_VADDR_W = 5
) (
    input  logic                              clk_i,
    input  logic                              async_rst_ni,
    input  logic [MAX_VADDR_W-1:0]            rd_addr_a_i,
    input  logic [MAX_VADDR_W-1:0]            rd_addr_b_i,
    output logic [vproc_pkg::VREG_W-1:0]      rd_data_a_o,
    output logic [vproc_pkg::VREG_W-1:0]      rd_data_b_o,
    input  logic                              alu_wb_valid_i,
    input  logic [MAX_VADDR_W-1:0]            alu_wb_vd_i,
    input  logic [vproc_pkg::VREG_W-1:0]      alu_wb_data_i,
    output logic                              alu_wb_grant_o,
    input  logic                              mul_wb_valid_i,
    input  logic [MAX_VADDR_W-1:0]            mul_wb_vd_i,
    input  logic [vproc_pkg::VREG_W-1:0]      mul_wb_data_i,
    output logic                              mul_wb_grant_o,
    output logic [(1 << MAX_VADDR_W)-1:0]     wb_clear_o
);
    localparam int unsigned VADDR_CNT = 1 << MAX_VADDR_W;

    logic [vproc_pkg::VREG_W-1:0] regs_q [VADDR_CNT];
    logic                         wr_en;
    logic [MAX_VADDR_W-1:0]       wr_vd;
    logic [vproc_pkg::VREG_W-1:0] wr_data;

    assign mul_wb_grant_o = mul_wb_valid_i;
    assign alu_wb_grant_o = alu_wb_valid_i & ~mul_wb_valid_i;

    assign wr_en   = alu_wb_valid_i | mul_wb_valid_i;
    assign wr_vd   = mul_wb_valid_i ? mul_wb_vd_i : alu_wb_vd_i;
    assign wr_data = mul_wb_valid_i ? mul_wb_data_i : alu_wb_data_i;

    // pending bit drops at the same edge the data lands
    assign wb_clear_o = wr_en ? (VADDR_CNT'(1) << wr_vd) : '0;

    always_ff @(posedge clk_i or negedge async_rst_ni) begin
        if (!async_rst_ni) begin
            for (int i = 0; i < VADDR_CNT; i++) begin
                regs_q[i] <= '0;
            end
        end else if (wr_en) begin
            regs_q[wr_vd] <= wr_data;
        end
    end

    assign rd_data_a_o = regs_q[rd_addr_a_i];
    assign rd_data_b_o = regs_q[rd_addr_b_i];

endmodule

`default_nettype wire

// File: source/vproc_alu_pipe.sv
// single-cycle lane-wise ADD/SUB/XOR/LI, result held until the write is granted
`timescale 1ns/1ps
`default_nettype none

module vproc_alu_pipe #(
    parameter int unsigned MAX_VADDR_W = 5
) (
    input  logic                              clk_i,
    input  logic                              async_rst_ni,
    vproc_issue_if.unit                       issue,
    output logic                              wb_valid_o,
    output logic [MAX_VADDR_W-1:0]            wb_vd_o,
    output logic [vproc_pkg::VREG_W-1:0]      wb_data_o,
    input  logic                              wb_grant_i
);
    localparam int unsigned LW = vproc_pkg::LANE_W;

    logic [vproc_pkg::VREG_W-1:0] res;
    logic                         fire;

    assign issue.ready = ~wb_valid_o | wb_grant_i;
    assign fire        = issue.valid & issue.ready;

    always_comb begin
        for (int l = 0; l < vproc_pkg::LANE_CNT; l++) begin
            case (issue.op)
                vproc_pkg::OP_ADD: res[l*LW +: LW] = issue.opa[l*LW +: LW] + issue.opb[l*LW +: LW];
                vproc_pkg::OP_SUB: res[l*LW +: LW] = issue.opa[l*LW +: LW] - issue.opb[l*LW +: LW];
                vproc_pkg::OP_XOR: res[l*LW +: LW] = issue.opa[l*LW +: LW] ^ issue.opb[l*LW +: LW];
                default:           res[l*LW +: LW] = issue.opb[l*LW +: LW];  // LI broadcast
            endcase
        end
    end

    always_ff @(posedge clk_i or negedge async_rst_ni) begin
        if (!async_rst_ni) begin
            wb_valid_o <= 1'b0;
        end else if (fire) begin
            wb_valid_o <= 1'b1;
        end else if (wb_grant_i) begin
            wb_valid_o <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (fire) begin
            wb_vd_o   <= issue.vd;
            wb_data_o <= res;
        end
    end

endmodule

`default_nettype wire

// File: source/vproc_mul_unit.sv
// shift-add multiplier, one multiplier bit per cycle over all lanes at once
// low 8 bits of each lane product only; result offered 8 cycles after issue
`timescale 1ns/1ps
`default_nettype none

module vproc_mul_unit #(
    parameter int unsigned MAX_VADDR_W = 5
) (
    input  logic                              clk_i,
    input  logic                              async_rst_ni,
    vproc_issue_if.unit                       issue,
    output logic                              wb_valid_o,
    output logic [MAX_VADDR_W-1:0]            wb_vd_o,
    output logic [vproc_pkg::VREG_W-1:0]      wb_data_o,
    input  logic                              wb_grant_i
);
    localparam int unsigned LW    = vproc_pkg::LANE_W;
    localparam int unsigned CNT_W = $clog2(LW);

    logic                         busy_q;
    logic                         done_q;
    logic [CNT_W-1:0]             cnt_q;
    logic [MAX_VADDR_W-1:0]       vd_q;
    logic [vproc_pkg::VREG_W-1:0] a_q, b_q, acc_q;
    logic [vproc_pkg::VREG_W-1:0] a_in, b_in, acc_in;
    logic [vproc_pkg::VREG_W-1:0] a_nx, b_nx, acc_nx;
    logic                         fire;

    assign issue.ready = ~busy_q & (~done_q | wb_grant_i);
    assign fire        = issue.valid & issue.ready;

    // first step already runs on the issue edge
    assign a_in   = fire ? issue.opa : a_q;
    assign b_in   = fire ? issue.opb : b_q;
    assign acc_in = fire ? '0 : acc_q;

    always_comb begin
        for (int l = 0; l < vproc_pkg::LANE_CNT; l++) begin
            acc_nx[l*LW +: LW] = b_in[l*LW] ? acc_in[l*LW +: LW] + a_in[l*LW +: LW]
                                            : acc_in[l*LW +: LW];
            a_nx[l*LW +: LW]   = a_in[l*LW +: LW] << 1;  // stays inside the lane
            b_nx[l*LW +: LW]   = b_in[l*LW +: LW] >> 1;
        end
    end

    always_ff @(posedge clk_i or negedge async_rst_ni) begin
        if (!async_rst_ni) begin
            busy_q <= 1'b0;
            done_q <= 1'b0;
            cnt_q  <= '0;
        end else if (fire) begin
            busy_q <= 1'b1;
            done_q <= 1'b0;
            cnt_q  <= '0;
        end else if (busy_q) begin
            cnt_q <= cnt_q + 1'b1;
            if (cnt_q == CNT_W'(LW - 2)) begin  // last of the remaining 7 steps
                busy_q <= 1'b0;
                done_q <= 1'b1;
            end
        end else if (wb_grant_i) begin
            done_q <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (fire || busy_q) begin
            a_q   <= a_nx;
            b_q   <= b_nx;
            acc_q <= acc_nx;
        end
        if (fire) begin
            vd_q <= issue.vd;
        end
    end

    assign wb_valid_o = done_q;
    assign wb_vd_o    = vd_q;
    assign wb_data_o  = acc_q;

endmodule

`default_nettype wire

// File: source/vproc_out_unit.sv
// streams vs1 out, one credit per word; the consumer must not return extra credits
`timescale 1ns/1ps
`default_nettype none

module vproc_out_unit #(
    parameter int unsigned OUT_CREDITS = 4
) (
    input  logic                              clk_i,
    input  logic                              async_rst_ni,
    vproc_issue_if.unit                       issue,
    output logic                              out_valid_o,
    output logic [vproc_pkg::VREG_W-1:0]      out_data_o,
    input  logic                              out_credit_i
);
    localparam int unsigned CNT_W = $clog2(OUT_CREDITS + 1);

    logic [CNT_W-1:0] credits_q;
    logic             fire;

    assign issue.ready = (credits_q != '0);
    assign fire        = issue.valid & issue.ready;

    always_ff @(posedge clk_i or negedge async_rst_ni) begin
        if (!async_rst_ni) begin
            credits_q   <= CNT_W'(OUT_CREDITS);
            out_valid_o <= 1'b0;
        end else begin
            // credit taken at issue, the pulse follows one cycle later
            credits_q   <= credits_q + CNT_W'(out_credit_i) - CNT_W'(fire);
            out_valid_o <= fire;
        end
    end

    always_ff @(posedge clk_i) begin
        if (fire) begin
            out_data_o <= issue.opa;
        end
    end

endmodule

`default_nettype wire

// File: source/vproc_top.sv
// vector issue subsystem top; in-order issue, completion is the vreg write or out_valid_o
// MAX_VADDR_W must stay 5 to match the instruction fields
`timescale 1ns/1ps
`default_nettype none

module vproc_top #(
    parameter int unsigned MAX_VADDR_W = 5,
    parameter int unsigned OUT_CREDITS = 4
) (
    input  logic                              clk_i,
    input  logic                              async_rst_ni,
    input  logic                              instr_valid_i,
    output logic                              instr_ready_o,
    input  logic [vproc_pkg::INSTR_W-1:0]     instr_i,
    output logic                              out_valid_o,
    output logic [vproc_pkg::VREG_W-1:0]      out_data_o,
    input  logic                              out_credit_i
);
    localparam int unsigned VADDR_CNT = 1 << MAX_VADDR_W;

    logic                         dec_valid;
    logic                         dec_ready;
    vproc_pkg::opcode_e           dec_op;
    vproc_pkg::unit_e             dec_unit;
    logic [MAX_VADDR_W-1:0]       dec_vd;
    logic [MAX_VADDR_W-1:0]       dec_vs1;
    logic [MAX_VADDR_W-1:0]       dec_vs2;
    logic [vproc_pkg::LANE_W-1:0] dec_imm;
    logic [VADDR_CNT-1:0]         dec_wr_map;
    logic [VADDR_CNT-1:0]         dec_rd_map;
    logic [vproc_pkg::VREG_W-1:0] rf_opa;
    logic [vproc_pkg::VREG_W-1:0] rf_opb;
    logic [VADDR_CNT-1:0]         wb_clear;

    logic                         alu_wb_valid;
    logic [MAX_VADDR_W-1:0]       alu_wb_vd;
    logic [vproc_pkg::VREG_W-1:0] alu_wb_data;
    logic                         alu_wb_grant;
    logic                         mul_wb_valid;
    logic [MAX_VADDR_W-1:0]       mul_wb_vd;
    logic [vproc_pkg::VREG_W-1:0] mul_wb_data;
    logic                         mul_wb_grant;

    vproc_issue_if #(.MAX_VADDR_W(MAX_VADDR_W)) alu_if ();
    vproc_issue_if #(.MAX_VADDR_W(MAX_VADDR_W)) mul_if ();
    vproc_issue_if #(.MAX_VADDR_W(MAX_VADDR_W)) out_if ();

    vproc_decoder #(.MAX_VADDR_W(MAX_VADDR_W)) u_decoder (
        .clk_i         (clk_i),
        .async_rst_ni  (async_rst_ni),
        .instr_valid_i (instr_valid_i),
        .instr_ready_o (instr_ready_o),
        .instr_i       (instr_i),
        .dec_valid_o   (dec_valid),
        .dec_ready_i   (dec_ready),
        .dec_op_o      (dec_op),
        .dec_unit_o    (dec_unit),
        .dec_vd_o      (dec_vd),
        .dec_vs1_o     (dec_vs1),
        .dec_vs2_o     (dec_vs2),
        .dec_imm_o     (dec_imm),
        .dec_wr_map_o  (dec_wr_map),
        .dec_rd_map_o  (dec_rd_map)
    );

    vproc_dispatcher #(.MAX_VADDR_W(MAX_VADDR_W)) u_dispatcher (
        .clk_i        (clk_i),
        .async_rst_ni (async_rst_ni),
        .dec_valid_i  (dec_valid),
        .dec_ready_o  (dec_ready),
        .dec_op_i     (dec_op),
        .dec_unit_i   (dec_unit),
        .dec_vd_i     (dec_vd),
        .dec_imm_i    (dec_imm),
        .dec_wr_map_i (dec_wr_map),
        .dec_rd_map_i (dec_rd_map),
        .rf_opa_i     (rf_opa),
        .rf_opb_i     (rf_opb),
        .alu_if       (alu_if),
        .mul_if       (mul_if),
        .out_if       (out_if),
        .wb_clear_i   (wb_clear),
        .pend_map_o   ()  // observation only
    );

    // operands read straight from the decoder entry
    vproc_vregfile #(.MAX_VADDR_W(MAX_VADDR_W)) u_vregfile (
        .clk_i          (clk_i),
        .async_rst_ni   (async_rst_ni),
        .rd_addr_a_i    (dec_vs1),
        .rd_addr_b_i    (dec_vs2),
        .rd_data_a_o    (rf_opa),
        .rd_data_b_o    (rf_opb),
        .alu_wb_valid_i (alu_wb_valid),
        .alu_wb_vd_i    (alu_wb_vd),
        .alu_wb_data_i  (alu_wb_data),
        .alu_wb_grant_o (alu_wb_grant),
        .mul_wb_valid_i (mul_wb_valid),
        .mul_wb_vd_i    (mul_wb_vd),
        .mul_wb_data_i  (mul_wb_data),
        .mul_wb_grant_o (mul_wb_grant),
        .wb_clear_o     (wb_clear)
    );

    vproc_alu_pipe #(.MAX_VADDR_W(MAX_VADDR_W)) u_alu (
        .clk_i        (clk_i),
        .async_rst_ni (async_rst_ni),
        .issue        (alu_if),
        .wb_valid_o   (alu_wb_valid),
        .wb_vd_o      (alu_wb_vd),
        .wb_data_o    (alu_wb_data),
        .wb_grant_i   (alu_wb_grant)
    );

    vproc_mul_unit #(.MAX_VADDR_W(MAX_VADDR_W)) u_mul (
        .clk_i        (clk_i),
        .async_rst_ni (async_rst_ni),
        .issue        (mul_if),
        .wb_valid_o   (mul_wb_valid),
        .wb_vd_o      (mul_wb_vd),
        .wb_data_o    (mul_wb_data),
        .wb_grant_i   (mul_wb_grant)
    );

    vproc_out_unit #(.OUT_CREDITS(OUT_CREDITS)) u_out (
        .clk_i        (clk_i),
        .async_rst_ni (async_rst_ni),
        .issue        (out_if),
        .out_valid_o  (out_valid_o),
        .out_data_o   (out_data_o),
        .out_credit_i (out_credit_i)
    );

endmodule

`default_nettype wire

// File: sim/tb_clk_gen.sv
// free-running testbench clock and power-on reset, active low
// reset drops 1 ns after the last reset edge to stay clear of the clock
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
    parameter int unsigned HALF_PERIOD_NS = 4,
    parameter int unsigned RST_CYCLES     = 4
) (
    output logic clk_o,
    output logic rst_no
);
    initial begin
        clk_o = 1'b0;
        forever #(HALF_PERIOD_NS) clk_o = ~clk_o;
    end

    initial begin
        rst_no = 1'b0;
        repeat (RST_CYCLES) @(posedge clk_o);
        #1;
        rst_no = 1'b1;
    end

endmodule

`default_nettype wire

// File: sim/tb_vproc.sv
// in-order reference model; every register only ever holds four equal lanes
// inputs change 1 ns after the rising edge, outputs are sampled at the falling edge
`timescale 1ns/1ps
`default_nettype none

module tb_vproc;
    localparam int unsigned OUT_CREDITS = 4;
    localparam int          STALL_LIMIT = 5000;
    localparam int          IDLE_LIMIT  = 20000;

    logic        clk;
    logic        rst_n;
    logic        instr_valid;
    logic        instr_ready;
    logic [31:0] instr;
    logic        out_valid;
    logic [31:0] out_data;
    logic        out_credit;

    logic [31:0] prog_q [$];      // words not yet driven
    logic [31:0] exp_q [$];       // expected OUT values, program order
    logic [31:0] model_regs [32];
    logic [31:0] exp_val;
    logic        withhold;        // consumer keeps its credits
    int          seed = 35;
    int          errors = 0;
    int          checks = 0;
    int          out_cnt = 0;
    int          credit_cnt = 0;
    string       test_name = "reset";

    tb_clk_gen u_clk_gen (.clk_o(clk), .rst_no(rst_n));

    vproc_top #(.MAX_VADDR_W(5), .OUT_CREDITS(OUT_CREDITS)) dut (
        .clk_i         (clk),
        .async_rst_ni  (rst_n),
        .instr_valid_i (instr_valid),
        .instr_ready_o (instr_ready),
        .instr_i       (instr),
        .out_valid_o   (out_valid),
        .out_data_o    (out_data),
        .out_credit_i  (out_credit)
    );

    function automatic logic [31:0] enc_reg(input logic [3:0] op, input logic [4:0] vd,
                                            input logic [4:0] vs1, input logic [4:0] vs2);
        return {op, vd, vs1, vs2, 13'd0};
    endfunction

    function automatic logic [31:0] enc_li(input logic [4:0] vd, input logic [7:0] imm);
        return {4'(vproc_pkg::OP_LI), vd, imm, 15'd0};
    endfunction

    // lane-wise, each lane wraps at 8 bits
    function automatic logic [31:0] lane_calc(input logic [3:0] op, input logic [31:0] a,
                                              input logic [31:0] b);
        logic [31:0] r;
        logic [7:0]  x;
        logic [7:0]  y;
        logic [15:0] prod;
        r = '0;
        for (int l = 0; l < 4; l++) begin
            x    = a[l*8 +: 8];
            y    = b[l*8 +: 8];
            prod = 16'(x) * 16'(y);
            case (op)
                vproc_pkg::OP_ADD: r[l*8 +: 8] = x + y;
                vproc_pkg::OP_SUB: r[l*8 +: 8] = x - y;
                vproc_pkg::OP_XOR: r[l*8 +: 8] = x ^ y;
                default:           r[l*8 +: 8] = prod[7:0];  // MUL keeps the low byte
            endcase
        end
        return r;
    endfunction

    task automatic apply_model(input logic [31:0] w);
        logic [3:0] op;
        logic [4:0] vd;
        logic [4:0] vs1;
        logic [4:0] vs2;
        op  = w[31:28];
        vd  = w[27:23];
        vs1 = w[22:18];
        vs2 = w[17:13];
        case (op)
            vproc_pkg::OP_ADD, vproc_pkg::OP_SUB, vproc_pkg::OP_XOR, vproc_pkg::OP_MUL: begin
                model_regs[vd] = lane_calc(op, model_regs[vs1], model_regs[vs2]);
            end
            vproc_pkg::OP_LI: model_regs[vd] = {4{w[22:15]}};
            vproc_pkg::OP_OUT: exp_q.push_back(model_regs[vs1]);
            default: ;  // unknown opcode, no effect
        endcase
    endtask

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("closing: %0d errors, %0d outputs checked", errors, checks);
        $display("Some tests failed");
        $finish;
    endtask

    function automatic bit is_idle();
        return prog_q.size() == 0 && !instr_valid && exp_q.size() == 0;
    endfunction

    task automatic wait_idle();
        int cnt;
        cnt = 0;
        while (!is_idle() && cnt < IDLE_LIMIT) begin
            @(negedge clk);
            cnt++;
        end
        if (!is_idle()) abort_run({test_name, ": outputs did not drain in time"});
    endtask

    // drives queued words; the model sees a word when its handshake is certain
    initial begin : instr_driver
        int   stall;
        logic accepted;
        stall = 0;
        forever begin
            @(negedge clk);
            accepted = instr_valid && instr_ready;
            if (accepted) begin
                apply_model(instr);
                stall = 0;
            end else if (instr_valid) begin
                stall++;
                if (stall > STALL_LIMIT) abort_run("instruction handshake timed out");
            end
            @(posedge clk);
            #1;
            if (accepted || !instr_valid) begin
                if (prog_q.size() != 0) begin
                    instr       = prog_q.pop_front();
                    instr_valid = 1'b1;
                end else begin
                    instr_valid = 1'b0;
                end
            end
        end
    end

    // credit consumer, returns one credit per output after a random delay
    initial begin : credit_consumer
        out_credit = 1'b0;
        forever begin
            @(posedge clk);
            #1;
            out_credit = rst_n && !withhold && (out_cnt > credit_cnt)
                         && (($random(seed) & 3) == 0);
        end
    end

    always @(negedge clk) begin
        if (rst_n && out_valid) begin
            out_cnt++;
            if (exp_q.size() == 0) begin
                errors++;
                $display("output %08h in %s with nothing expected", out_data, test_name);
            end else begin
                exp_val = exp_q.pop_front();
                checks++;
                assert (out_data == exp_val) else begin
                    errors++;
                    $display("mismatch %s expected %08h actual %08h",
                             test_name, exp_val, out_data);
                end
            end
        end
        if (rst_n && out_credit) credit_cnt++;
    end

    assert property (@(posedge clk) !rst_n |-> !out_valid) else begin
        errors++;
        $display("out_valid_o high during reset");
    end

    assert property (@(posedge clk) disable iff (!rst_n)
                     (out_cnt - credit_cnt) <= int'(OUT_CREDITS))
    else begin
        errors++;
        $display("more outputs in flight than credits allow");
    end

    initial begin : stimulus
        int          cnt;
        int          base;
        logic [3:0]  ops [6];
        logic [31:0] r;
        ops = '{vproc_pkg::OP_ADD, vproc_pkg::OP_SUB, vproc_pkg::OP_XOR,
                vproc_pkg::OP_LI, vproc_pkg::OP_MUL, vproc_pkg::OP_OUT};
        instr_valid = 1'b0;
        instr       = '0;
        withhold    = 1'b0;
        for (int i = 0; i < 32; i++) model_regs[i] = '0;

        cnt = 0;
        while (!rst_n && cnt < 100) begin
            @(negedge clk);
            cnt++;
        end
        if (!rst_n) abort_run("reset never released");
        @(negedge clk);
        assert (instr_ready && !out_valid) else begin
            errors++;
            $display("wrong handshake state right after reset");
        end

        test_name = "lane_arith";
        prog_q.push_back(enc_li(1, 8'hf0));
        prog_q.push_back(enc_li(2, 8'h25));
        prog_q.push_back(enc_reg(vproc_pkg::OP_ADD, 3, 1, 2));  // wraps
        prog_q.push_back(enc_reg(vproc_pkg::OP_SUB, 4, 2, 1));  // borrows
        prog_q.push_back(enc_reg(vproc_pkg::OP_XOR, 5, 3, 4));
        for (int i = 1; i <= 5; i++) prog_q.push_back(enc_reg(vproc_pkg::OP_OUT, 0, 5'(i), 0));
        wait_idle();

        test_name = "multiply";
        prog_q.push_back(enc_li(6, 8'h13));
        prog_q.push_back(enc_li(7, 8'h0f));
        prog_q.push_back(enc_reg(vproc_pkg::OP_MUL, 8, 6, 7));
        prog_q.push_back(enc_reg(vproc_pkg::OP_ADD, 9, 8, 6));  // needs the MUL result
        prog_q.push_back(enc_reg(vproc_pkg::OP_OUT, 0, 9, 0));
        prog_q.push_back(enc_reg(vproc_pkg::OP_MUL, 8, 8, 1));
        prog_q.push_back(enc_reg(vproc_pkg::OP_OUT, 0, 8, 0));
        wait_idle();

        test_name = "unknown_op";
        for (int i = 0; i < 12; i++) begin
            r = $random(seed);
            prog_q.push_back({4'(6 + i % 10), r[27:0]});
        end
        for (int i = 0; i < 10; i++) prog_q.push_back(enc_reg(vproc_pkg::OP_OUT, 0, 5'(i), 0));
        wait_idle();

        test_name = "random_mix";
        for (int n = 0; n < 200; n++) begin
            r = $random(seed);
            if (ops[r[31:16] % 6] == vproc_pkg::OP_LI) begin
                prog_q.push_back(enc_li(5'(r[2:0]), r[15:8]));
            end else begin
                prog_q.push_back(enc_reg(ops[r[31:16] % 6], 5'(r[2:0]), 5'(r[5:3]), 5'(r[8:6])));
            end
        end
        for (int i = 0; i < 8; i++) prog_q.push_back(enc_reg(vproc_pkg::OP_OUT, 0, 5'(i), 0));
        wait_idle();

        test_name = "credits";
        cnt = 0;
        while (out_cnt != credit_cnt && cnt < IDLE_LIMIT) begin
            @(negedge clk);
            cnt++;
        end
        if (out_cnt != credit_cnt) abort_run("consumer credits did not come back in time");
        withhold = 1'b1;
        for (int i = 0; i < OUT_CREDITS + 3; i++) begin
            prog_q.push_back(enc_reg(vproc_pkg::OP_OUT, 0, 5'(i), 0));
        end
        cnt = 0;
        while (out_cnt - credit_cnt < int'(OUT_CREDITS) && cnt < 1000) begin
            @(negedge clk);
            cnt++;
        end
        if (out_cnt - credit_cnt < int'(OUT_CREDITS)) abort_run("credits were never used up");
        base = out_cnt;
        repeat (30) @(negedge clk);
        // three OUTs still owed, wherever they wait on the way in
        assert (out_cnt == base
                && exp_q.size() + prog_q.size() + int'(instr_valid) == 3) else begin
            errors++;
            $display("outputs went on while the consumer held every credit");
        end
        withhold = 1'b0;
        wait_idle();

        $display("closing: %0d errors, %0d outputs checked", errors, checks);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: sim.f
source/vproc_pkg.sv
source/vproc_issue_if.sv
source/vproc_decoder.sv
source/vproc_dispatcher.sv
source/vproc_vregfile.sv
source/vproc_alu_pipe.sv
source/vproc_mul_unit.sv
source/vproc_out_unit.sv
source/vproc_top.sv
sim/tb_clk_gen.sv
sim/tb_vproc.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the vector issue testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal --top-module tb_vproc -f sim.f -Mdir obj_dir -o vproc_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

sim_out="$(./obj_dir/vproc_sim)"
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -qx "All tests passed"; then
    exit 0
fi
echo "pass message not found"
exit 1
